// File: sim.f
+incdir+.
dram_pkg.sv
sd_pkg.sv
bridge_xfer_if.sv
dram_reader.sv
sd_block_writer.sv
byte_output.sv
bridge_top.sv
tb_sd_card.sv
tb_bridge.sv

// File: Makefile
# Verilator build and run of the DRAM-to-SD bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_bridge
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// File: tb_bridge.sv
/* Testbench for the DRAM-to-SD bridge
   Clock, reset, DRAM responder, SD card model, request stimulus and checks */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_bridge;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_REQS     = 20;
    // Worst case for one request with the longest stalls and card delays
    localparam int REQ_CYCLES   = 250;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_REQS * REQ_CYCLES) * CLK_PERIOD;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic [`BRIDGE_REQ_ADDR_W-1:0]  addr_dram;
    logic [`BRIDGE_SD_ADDR_W-1:0]   addr_sd;
    logic                           out_valid;
    logic [7:0]                     out_data;
    logic                           ar_valid;
    logic [`BRIDGE_DRAM_ADDR_W-1:0] ar_addr;
    logic                           ar_ready;
    logic                           r_valid;
    logic [`BRIDGE_BLOCK_W-1:0]     r_data;
    logic                           r_ready;
    logic                           miso;
    logic                           mosi;
    logic                           card_busy;

    integer                         seed = 77058;
    int                             tb_errors = 0;
    int                             card_errors;
    int                             req_idx;
    string                          test_name;
    logic                           started;
    logic                           expect_accept;
    logic [`BRIDGE_DRAM_ADDR_W-1:0] exp_ar_addr;
    logic [`BRIDGE_SD_ADDR_W-1:0]   exp_sd_addr;
    logic [`BRIDGE_BLOCK_W-1:0]     exp_block;

    bridge_top u_bridge_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .addr_dram (addr_dram),
        .addr_sd   (addr_sd),
        .out_valid (out_valid),
        .out_data  (out_data),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r_data    (r_data),
        .r_ready   (r_ready),
        .miso      (miso),
        .mosi      (mosi)
    );

    tb_sd_card u_sd_card (
        .clk         (clk),
        .rst_n       (rst_n),
        .mosi        (mosi),
        .miso        (miso),
        .busy        (card_busy),
        .exp_sd_addr (exp_sd_addr),
        .exp_block   (exp_block),
        .req_idx     (req_idx),
        .err_count   (card_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic note_failure(input string msg);
        tb_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic note_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        tb_errors++;
        $display("ERROR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    // ####################
    // DRAM responder
    // ####################
    initial
    begin : dram_responder
        int delay;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        forever
        begin
            @(posedge clk);
            if (ar_valid)
            begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge clk);
                ar_ready <= 1'b1;
                @(posedge clk);
                ar_ready <= 1'b0;
                while (!r_ready) @(posedge clk);
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge clk);
                r_valid <= 1'b1;
                r_data  <= exp_block;
                @(posedge clk);
                r_valid <= 1'b0;
                r_data  <= '0;
            end
        end
    end

    // ####################
    // Protocol checks
    // ####################
    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !ar_valid && !r_ready && !out_valid && mosi)
        else note_failure("outputs left their idle values before the first request");

    a_ar_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && expect_accept |=> ar_valid && ar_addr == exp_ar_addr)
        else note_mismatch("ar_valid:ar_addr", 64'({1'b1, exp_ar_addr}),
                           64'({ar_valid, ar_addr}));

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else note_failure("read address request changed during an ar_ready stall");

    a_r_after_ar: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(r_ready) |-> $past(ar_valid && ar_ready))
        else note_failure("r_ready rose without a completed address handshake");

    a_busy_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !expect_accept |=> !ar_valid)
        else note_failure("a request sent while busy started a DRAM read");

    a_no_out_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        card_busy |-> !out_valid)
        else note_failure("out_valid rose while the card held busy");

    a_out_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0)
        else note_mismatch("idle out_data", 64'd0, 64'(out_data));

    // ####################
    // Stimulus
    // ####################
    task automatic check_bytes();
        logic [7:0] exp_byte;
        do @(posedge clk); while (!out_valid);
        for (int k = 0; k < `BRIDGE_OUT_BYTES; k++)
        begin
            exp_byte = exp_block[(7 - k) * 8 +: 8];
            assert (out_valid) else note_failure($sformatf("out_valid dropped at byte %0d", k));
            assert (out_data == exp_byte)
                else note_mismatch($sformatf("byte %0d", k), 64'(exp_byte), 64'(out_data));
            @(posedge clk);
        end
        assert (!out_valid) else note_failure("out_valid stayed high after the last byte");
    endtask

    task automatic run_request(input int n);
        logic [`BRIDGE_REQ_ADDR_W-1:0] req_addr;
        req_idx     = n;
        test_name   = $sformatf("req%0d", n);
        req_addr    = `BRIDGE_REQ_ADDR_W'($random(seed));
        exp_ar_addr = `BRIDGE_DRAM_ADDR_W'(req_addr);
        exp_sd_addr = $random(seed);
        exp_block   = {$random(seed), $random(seed)};
        @(posedge clk);
        in_valid      <= 1'b1;
        addr_dram     <= req_addr;
        addr_sd       <= exp_sd_addr;
        expect_accept <= 1'b1;
        started       <= 1'b1;
        @(posedge clk);
        in_valid      <= 1'b0;
        expect_accept <= 1'b0;
        do @(posedge clk); while (!(r_valid && r_ready));
        // Extra request while the block is in flight
        repeat (2) @(posedge clk);
        in_valid  <= 1'b1;
        addr_dram <= `BRIDGE_REQ_ADDR_W'($random(seed));
        addr_sd   <= $random(seed);
        @(posedge clk);
        in_valid <= 1'b0;
        check_bytes();
    endtask

    initial
    begin : stimulus
        int errs_before;
        int passed;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        addr_dram     = '0;
        addr_sd       = '0;
        started       = 1'b0;
        expect_accept = 1'b0;
        exp_ar_addr   = '0;
        exp_sd_addr   = '0;
        exp_block     = '0;
        req_idx       = 0;
        test_name     = "reset";
        passed        = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int n = 0; n < NUM_REQS; n++)
        begin
            errs_before = tb_errors + card_errors;
            run_request(n);
            if (tb_errors + card_errors == errs_before)
            begin
                passed++;
                $display("%s: passed", test_name);
            end
            else
                $display("%s: failed", test_name);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_REQS, passed, NUM_REQS - passed, tb_errors + card_errors);
        if (tb_errors + card_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the requests did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: tb_sd_card.sv
/* Behavioral SD card in SPI mode
   Decodes CMD24 and the data frame from mosi, answers on miso, checks both frames */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_sd_card #(
    parameter int SEED = 77058
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mosi,
    output logic                          miso,
    output logic                          busy,
    input  logic [`BRIDGE_SD_ADDR_W-1:0]  exp_sd_addr,
    input  logic [`BRIDGE_BLOCK_W-1:0]    exp_block,
    input  int                            req_idx,
    output int                            err_count
);

    localparam logic [5:0] CMD24         = 6'd24;
    // Data response token, data accepted
    localparam logic [7:0] DATA_ACCEPTED = 8'h05;
    localparam int         FRAME_END     = `BRIDGE_DATA_FRAME_BITS + 1;

    integer seed = SEED;

    // ####################
    // Reference CRCs
    // ####################
    // Shift register form, taps at x^3 and x^0
    function automatic logic [6:0] crc7_model(input logic [39:0] bits);
        logic [6:0] r;
        logic       fb;
        r = '0;
        for (int i = 39; i >= 0; i--)
        begin
            fb = bits[i] ^ r[6];
            r  = {r[5:3], r[2] ^ fb, r[1:0], fb};
        end
        return r;
    endfunction

    // Taps at x^12, x^5 and x^0
    function automatic logic [15:0] crc16_model(input logic [63:0] bits);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 63; i >= 0; i--)
        begin
            fb = bits[i] ^ r[15];
            r  = {r[14:12], r[11] ^ fb, r[10:5], r[4] ^ fb, r[3:0], fb};
        end
        return r;
    endfunction

    task automatic flag_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        err_count++;
        $display("ERROR req%0d %s: expected %0h actual %0h", req_idx, what, expected, actual);
    endtask

    // ####################
    // Card behavior
    // ####################
    initial
    begin : card_model
        logic [`BRIDGE_CMD_BITS-1:0]        cmd;
        logic [`BRIDGE_CMD_BITS-1:0]        exp_cmd;
        logic [`BRIDGE_DATA_FRAME_BITS-1:0] frame;
        int                                 resp_delay;
        int                                 busy_cycles;
        miso      = 1'b1;
        busy      = 1'b0;
        err_count = 0;
        forever
        begin
            @(posedge clk);
            if (rst_n && !mosi)
            begin
                // Start bit of the command is already on the line
                cmd[`BRIDGE_CMD_BITS-1] = mosi;
                for (int i = `BRIDGE_CMD_BITS - 2; i >= 0; i--)
                begin
                    @(posedge clk);
                    cmd[i] = mosi;
                end
                exp_cmd[47:8] = {1'b0, 1'b1, CMD24, exp_sd_addr};
                exp_cmd[7:1]  = crc7_model(exp_cmd[47:8]);
                exp_cmd[0]    = 1'b1;
                assert (cmd == exp_cmd)
                    else flag_mismatch("command frame", 64'(exp_cmd), 64'(cmd));

                resp_delay  = 1 + ($unsigned($random(seed)) % 8);
                busy_cycles = 1 + ($unsigned($random(seed)) % 20);
                repeat (resp_delay) @(posedge clk);

                // R1 of all zeros, the data frame follows its first bit
                miso <= 1'b0;
                for (int k = 1; k <= FRAME_END; k++)
                begin
                    @(posedge clk);
                    if (k == `BRIDGE_RESP_BITS)
                        miso <= 1'b1;
                    if (k >= 2)
                        frame[FRAME_END - k] = mosi;
                end
                assert (frame[101:81] == '1)
                    else flag_mismatch("gap ones", 64'h1f_ffff, 64'(frame[101:81]));
                assert (!frame[80])
                    else flag_mismatch("data start bit", 64'd0, 64'(frame[80]));
                assert (frame[79:16] == exp_block)
                    else flag_mismatch("data block", exp_block, frame[79:16]);
                assert (frame[15:0] == crc16_model(exp_block))
                    else flag_mismatch("data crc16", 64'(crc16_model(exp_block)),
                                       64'(frame[15:0]));

                // Data response token, then busy
                for (int k = 7; k >= 0; k--)
                begin
                    miso <= DATA_ACCEPTED[k];
                    @(posedge clk);
                    assert (mosi) else flag_mismatch("mosi in data response", 64'd1, 64'(mosi));
                end
                miso <= 1'b0;
                busy <= 1'b1;
                repeat (busy_cycles)
                begin
                    @(posedge clk);
                    assert (mosi) else flag_mismatch("mosi in busy", 64'd1, 64'(mosi));
                end
                miso <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: bridge_top.sv
/* DRAM-to-SD bridge top level
   Chains the DRAM reader, SD block writer and byte output */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module bridge_top
    import dram_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    // Request
    input  logic                           in_valid,
    input  logic [`BRIDGE_REQ_ADDR_W-1:0]  addr_dram,
    input  logic [`BRIDGE_SD_ADDR_W-1:0]   addr_sd,
    // Byte stream
    output logic                           out_valid,
    output logic [7:0]                     out_data,
    // DRAM read channels
    output logic                           ar_valid,
    output dram_addr_t                     ar_addr,
    input  logic                           ar_ready,
    input  logic                           r_valid,
    input  block_t                         r_data,
    output logic                           r_ready,
    // SD card in SPI mode
    input  logic                           miso,
    output logic                           mosi
);

    bridge_xfer_if u_xfer ();

    dram_reader u_dram_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .addr_dram (addr_dram),
        .addr_sd   (addr_sd),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r_data    (r_data),
        .r_ready   (r_ready),
        .xfer      (u_xfer.reader)
    );

    sd_block_writer u_sd_block_writer (
        .clk   (clk),
        .rst_n (rst_n),
        .miso  (miso),
        .mosi  (mosi),
        .xfer  (u_xfer.writer)
    );

    byte_output u_byte_output (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_data  (out_data),
        .xfer      (u_xfer.out)
    );

endmodule

// File: byte_output.sv
/* Output stage
   Streams the held block as eight bytes, MSB first, after the card write */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module byte_output (
    input  logic        clk,
    input  logic        rst_n,
    output logic        out_valid,
    output logic [7:0]  out_data,
    bridge_xfer_if.out  xfer
);

    localparam int IDX_W = $clog2(`BRIDGE_OUT_BYTES);

    // Index of the next byte to load
    logic [IDX_W-1:0] byte_idx;

    // Counter wrapped to zero once the last byte is on the bus
    assign xfer.out_done = out_valid && (byte_idx == '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out_data  <= '0;
            byte_idx  <= '0;
        end
        else if (xfer.wr_done)
        begin
            out_valid <= 1'b1;
            out_data  <= xfer.blk_data[`BRIDGE_BLOCK_W-1 -: 8];
            byte_idx  <= IDX_W'(1);
        end
        else if (xfer.out_done)
        begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end
        else if (out_valid)
        begin
            out_data <= xfer.blk_data[(`BRIDGE_OUT_BYTES - 1 - int'(byte_idx)) * 8 +: 8];
            byte_idx <= byte_idx + 1'b1;
        end
    end

    a_out_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid [*`BRIDGE_OUT_BYTES] |=> !out_valid)
        else $error("byte_output: out_valid held past the last byte");

endmodule

// File: sd_block_writer.sv
/* SD card write stage in SPI mode
   Sends CMD24 and the data frame on mosi, then follows response and busy on miso */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module sd_block_writer
    import sd_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           miso,
    output logic           mosi,
    bridge_xfer_if.writer  xfer
);

    // One counter covers the longest frame
    localparam int CNT_W     = $clog2(`BRIDGE_DATA_FRAME_BITS);
    // Bit index width within the command frame
    localparam int CMD_IDX_W = $clog2(`BRIDGE_CMD_BITS);

    sd_wr_state_e                       state;
    logic [CNT_W-1:0]                   bit_cnt;
    logic [`BRIDGE_CMD_BITS-9:0]        cmd_body;
    logic [`BRIDGE_CMD_BITS-1:0]        cmd_frame;
    logic [`BRIDGE_DATA_FRAME_BITS-1:0] data_frame;

    // ####################
    // Frame assembly
    // ####################
    assign cmd_body   = {1'b0, 1'b1, SD_CMD_WRITE_BLOCK, xfer.sd_addr};
    assign cmd_frame  = {cmd_body, sd_crc7(cmd_body), 1'b1};
    assign data_frame = {{`BRIDGE_GAP_BITS{1'b1}}, 1'b0, xfer.blk_data,
                         sd_crc16(xfer.blk_data)};

    // Card released busy
    assign xfer.wr_done = (state == SD_WAIT_BUSY) && miso;

    // ####################
    // Writer FSM
    // ####################
    // bit_cnt tracks the index of the bit now on mosi
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= SD_IDLE;
            bit_cnt <= '0;
            mosi    <= 1'b1;
        end
        else
        begin
            case (state)
                SD_IDLE:
                begin
                    if (xfer.blk_valid)
                    begin
                        state   <= SD_SEND_CMD;
                        bit_cnt <= CNT_W'(`BRIDGE_CMD_BITS - 1);
                        mosi    <= cmd_frame[`BRIDGE_CMD_BITS-1];
                    end
                end
                SD_SEND_CMD:
                begin
                    if (bit_cnt == '0)
                    begin
                        state <= SD_WAIT_RESP;
                        mosi  <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt - 1'b1;
                        mosi    <= cmd_frame[CMD_IDX_W'(bit_cnt - 1'b1)];
                    end
                end
                SD_WAIT_RESP:
                begin
                    // Response start bit
                    if (!miso)
                    begin
                        state   <= SD_SEND_DATA;
                        bit_cnt <= CNT_W'(`BRIDGE_DATA_FRAME_BITS - 1);
                        mosi    <= data_frame[`BRIDGE_DATA_FRAME_BITS-1];
                    end
                end
                SD_SEND_DATA:
                begin
                    if (bit_cnt == '0)
                    begin
                        state   <= SD_DATA_RESP;
                        bit_cnt <= CNT_W'(`BRIDGE_RESP_BITS - 1);
                        mosi    <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt - 1'b1;
                        mosi    <= data_frame[bit_cnt - 1'b1];
                    end
                end
                SD_DATA_RESP:
                begin
                    if (bit_cnt == '0)
                        state <= SD_WAIT_BUSY;
                    else
                        bit_cnt <= bit_cnt - 1'b1;
                end
                SD_WAIT_BUSY:
                begin
                    if (miso)
                        state <= SD_IDLE;
                end
                default:
                begin
                    state <= SD_IDLE;
                    mosi  <= 1'b1;
                end
            endcase
        end
    end

    a_mosi_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !(state inside {SD_SEND_CMD, SD_SEND_DATA}) |-> mosi)
        else $error("sd_block_writer: mosi low outside a frame");

endmodule

// File: dram_reader.sv
/* DRAM read stage
   Latches a request, runs the AR and R handshakes, holds the block until output ends */
`timescale 1ns/1ps
`include "bridge_macros.svh"

module dram_reader
    import dram_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [`BRIDGE_REQ_ADDR_W-1:0]  addr_dram,
    input  logic [`BRIDGE_SD_ADDR_W-1:0]   addr_sd,
    output logic                           ar_valid,
    output dram_addr_t                     ar_addr,
    input  logic                           ar_ready,
    input  logic                           r_valid,
    input  block_t                         r_data,
    output logic                           r_ready,
    bridge_xfer_if.reader                  xfer
);

    dram_rd_state_e state;

    // ####################
    // Handshake FSM
    // ####################
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= RD_IDLE;
            ar_valid       <= 1'b0;
            ar_addr        <= '0;
            r_ready        <= 1'b0;
            xfer.blk_valid <= 1'b0;
        end
        else
        begin
            xfer.blk_valid <= 1'b0;
            case (state)
                RD_IDLE:
                begin
                    // Requests arriving while busy are dropped
                    if (in_valid)
                    begin
                        state    <= RD_ADDR;
                        ar_valid <= 1'b1;
                        ar_addr  <= {{(`BRIDGE_DRAM_ADDR_W - `BRIDGE_REQ_ADDR_W){1'b0}},
                                     addr_dram};
                    end
                end
                RD_ADDR:
                begin
                    if (ar_ready)
                    begin
                        state    <= RD_DATA;
                        ar_valid <= 1'b0;
                        ar_addr  <= '0;
                        r_ready  <= 1'b1;
                    end
                end
                RD_DATA:
                begin
                    if (r_valid)
                    begin
                        state          <= RD_HOLD;
                        r_ready        <= 1'b0;
                        xfer.blk_valid <= 1'b1;
                    end
                end
                RD_HOLD:
                begin
                    if (xfer.out_done)
                        state <= RD_IDLE;
                end
                default:
                begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Block and card address, held through the SD write and byte output
    always_ff @(posedge clk)
    begin
        if (state == RD_IDLE && in_valid)
            xfer.sd_addr <= addr_sd;
        if (state == RD_DATA && r_valid)
            xfer.blk_data <= r_data;
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("dram_reader: AR request changed before ar_ready");

endmodule

// File: bridge_xfer_if.sv
/* Block hand-off between the reader, SD writer and byte output stages */
`timescale 1ns/1ps
`include "bridge_macros.svh"

interface bridge_xfer_if
    import dram_pkg::*;
();

    logic                          blk_valid;
    block_t                        blk_data;
    logic [`BRIDGE_SD_ADDR_W-1:0]  sd_addr;
    logic                          wr_done;
    logic                          out_done;

    // Block source, freed by out_done
    modport reader (output blk_valid, blk_data, sd_addr, input out_done);

    modport writer (input blk_valid, blk_data, sd_addr, output wr_done);

    // Byte streamer after the card write
    modport out (input blk_data, wr_done, output out_done);

endinterface

// File: sd_pkg.sv
/* SD card side definitions
   Writer states, command index and the CRC7 and CRC16 generators */
`include "bridge_macros.svh"

package sd_pkg;

    typedef enum logic [5:0] {
        SD_CMD_WRITE_BLOCK = 6'd24
    } sd_cmd_e;

    typedef enum logic [2:0] {
        SD_IDLE,
        SD_SEND_CMD,
        SD_WAIT_RESP,
        SD_SEND_DATA,
        SD_DATA_RESP,
        SD_WAIT_BUSY
    } sd_wr_state_e;

    // CRC7 over the first 40 command bits, MSB first
    function automatic logic [6:0] sd_crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--)
        begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb)
                crc = crc ^ `BRIDGE_CRC7_POLY;
        end
        return crc;
    endfunction

    // CRC16-CCITT over the data block, zero seed
    function automatic logic [15:0] sd_crc16(input logic [63:0] data);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        for (int i = 63; i >= 0; i--)
        begin
            fb  = data[i] ^ crc[15];
            crc = {crc[14:0], 1'b0};
            if (fb)
                crc = crc ^ `BRIDGE_CRC16_POLY;
        end
        return crc;
    endfunction

endpackage

// File: dram_pkg.sv
/* DRAM side definitions
   Reader states and the address and block types */
`include "bridge_macros.svh"

package dram_pkg;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_HOLD
    } dram_rd_state_e;

    typedef logic [`BRIDGE_DRAM_ADDR_W-1:0] dram_addr_t;

    typedef logic [`BRIDGE_BLOCK_W-1:0] block_t;

endpackage

// File: bridge_macros.svh
/* DRAM-to-SD bridge constants
   Widths, SPI frame lengths, CRC polynomials and output byte count */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// ####################
// Widths
// ####################
`define BRIDGE_DRAM_ADDR_W      32
`define BRIDGE_REQ_ADDR_W       13
`define BRIDGE_BLOCK_W          64
`define BRIDGE_SD_ADDR_W        32

// ####################
// SPI frame lengths
// ####################
// Start, transmit, index, argument, CRC7, end
`define BRIDGE_CMD_BITS         48
// Ones sent ahead of the data start bit
`define BRIDGE_GAP_BITS         21
`define BRIDGE_DATA_FRAME_BITS  102
`define BRIDGE_RESP_BITS        8

// x^7 + x^3 + 1
`define BRIDGE_CRC7_POLY        7'h09
// CCITT polynomial
`define BRIDGE_CRC16_POLY       16'h1021

`define BRIDGE_OUT_BYTES        8

`endif
